//--- eth_assert.sv
`timescale 1ns/1ps

module eth_assert (
   input logic                 clk,
   input logic                 rst,
   input logic                 psel,
   input logic                 penable,
   input logic                 pready,
   input logic                 tx_en,
   input eth_pkg::eth_nibble_t tx_data,
   input logic                 phy_resetn
);

   int fail_cnt = 0;

   // At most one wait state per transfer
   a_apb_wait: assert property (@(posedge clk) disable iff (rst)
      (psel && penable && !pready) |=> pready)
   else begin
      $error("APB access stalled for more than one wait state");
      fail_cnt++;
   end

   a_tx_phy: assert property (@(posedge clk) disable iff (rst)
      tx_en |-> phy_resetn)
   else begin
      $error("tx_en high while the PHY is in reset");
      fail_cnt++;
   end

   a_tx_known: assert property (@(posedge clk) disable iff (rst)
      tx_en |-> !$isunknown(tx_data))
   else begin
      $error("tx_data unknown while tx_en is high");
      fail_cnt++;
   end

endmodule

bind eth_top eth_assert u_eth_assert (
   .clk        (clk),
   .rst        (rst),
   .psel       (psel),
   .penable    (penable),
   .pready     (pready),
   .tx_en      (tx_en),
   .tx_data    (tx_data),
   .phy_resetn (phy_resetn)
);

//--- eth_buffer.sv
`timescale 1ns/1ps

module eth_buffer #(
   parameter int DEPTH_AW = 6
) (
   input  logic                clk,
   input  logic                we,
   input  logic [DEPTH_AW-1:0] waddr,
   input  logic [DEPTH_AW-1:0] raddr,
   input  eth_pkg::eth_byte_t  wdata,
   output eth_pkg::eth_byte_t  rdata
);

   import eth_pkg::*;

   eth_byte_t mem [2**DEPTH_AW];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // Registered read, one cycle behind raddr
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

//--- eth_defines.svh
`ifndef ETH_DEFINES_SVH
`define ETH_DEFINES_SVH

// Buffer and bus sizes
`define ETH_BUF_AW          6
`define ETH_APB_AW          12

// Register map
`define ETH_STATUS          12'h000
`define ETH_CONTROL         12'h004
`define ETH_MAC_LO          12'h008
`define ETH_MAC_HI          12'h00C
`define ETH_TX_NBYTES       12'h010
`define ETH_RX_NBYTES       12'h014

// Bit 11 selects the buffer window
`define ETH_DATA_BASE       12'h800

`define ETH_PHY_RST_CYC     64

// Framing
`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_SFD_BYTE        8'hD5
`define ETH_PREAMBLE_LEN    7

// Locally administered station address
`define ETH_MAC_RESET       48'h02_00_00_00_00_01

`endif

//--- eth_phy_reset.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_phy_reset (
   input  logic clk,
   input  logic rst,
   output logic phy_resetn
);

   localparam int CW = $clog2(`ETH_PHY_RST_CYC);
   localparam logic [CW-1:0] TOP = CW'(`ETH_PHY_RST_CYC - 1);

   logic [CW-1:0] cnt;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cnt        <= '0;
         phy_resetn <= 1'b0;
      end else begin
         // Saturates at TOP
         if (cnt != TOP) begin
            cnt <= cnt + 1'b1;
         end
         phy_resetn <= (cnt == TOP);
      end
   end

endmodule

//--- eth_pkg.sv
`include "eth_defines.svh"

package eth_pkg;

   typedef logic [7:0] eth_byte_t;
   typedef logic [3:0] eth_nibble_t;

   // Buffer address and byte count, count is one bit wider
   typedef logic [`ETH_BUF_AW-1:0] eth_addr_t;
   typedef logic [`ETH_BUF_AW:0]   eth_count_t;

   typedef logic [47:0] eth_mac_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_PREAMBLE,
      TX_SFD,
      TX_PAYLOAD
   } tx_state_t;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_HUNT,
      RX_DEST,
      RX_BODY,
      RX_DONE,
      RX_DROP
   } rx_state_t;

endpackage

//--- eth_regs.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_regs (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [`ETH_APB_AW-1:0]  paddr,
   input  logic [31:0]             pwdata,
   output logic [31:0]             prdata,
   output logic                    pready,
   output logic                    pslverr,
   input  logic                    phy_resetn,
   input  logic                    tx_done,
   input  logic                    rx_done,
   input  eth_pkg::eth_byte_t      rx_rdata,
   output logic                    tx_wr,
   output eth_pkg::eth_addr_t      tx_waddr,
   output eth_pkg::eth_byte_t      tx_wdata,
   output eth_pkg::eth_addr_t      rx_raddr,
   output eth_pkg::eth_count_t     tx_nbytes,
   output eth_pkg::eth_count_t     rx_nbytes,
   output eth_pkg::eth_mac_t       mac_addr,
   output logic                    tx_send,
   output logic                    rx_arm
);

   logic data_sel;
   logic access;
   logic wr_en;
   logic rd_data_win;
   logic rd_pend;
   logic ctrl_wr;
   logic tx_rdy_q;
   logic rx_rdy_q;
   logic tx_ready;
   logic rx_ready;

   assign data_sel    = (paddr & `ETH_DATA_BASE) == `ETH_DATA_BASE;
   assign access      = psel & penable;
   assign wr_en       = access & pwrite;
   assign rd_data_win = access & ~pwrite & data_sel;

   // Buffer reads need one extra access cycle
   assign pready  = access & (~rd_data_win | rd_pend);
   assign pslverr = 1'b0;

   assign ctrl_wr = wr_en & ~data_sel & (paddr == `ETH_CONTROL);

   assign tx_wr    = wr_en & data_sel;
   assign tx_waddr = paddr[`ETH_BUF_AW-1:0];
   assign tx_wdata = pwdata[7:0];
   assign rx_raddr = paddr[`ETH_BUF_AW-1:0];

   // Flags stay hidden while the PHY is in reset
   assign tx_ready = tx_rdy_q & phy_resetn;
   assign rx_ready = rx_rdy_q & phy_resetn;

   assign tx_send = ctrl_wr & pwdata[0] & tx_ready;
   assign rx_arm  = ctrl_wr & pwdata[1] & rx_ready;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= rd_data_win & ~rd_pend;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         mac_addr  <= `ETH_MAC_RESET;
         tx_nbytes <= '0;
         rx_nbytes <= '0;
      end else if (wr_en && !data_sel) begin
         case (paddr)
            `ETH_MAC_LO:    mac_addr[23:0]  <= pwdata[23:0];
            `ETH_MAC_HI:    mac_addr[47:24] <= pwdata[23:0];
            `ETH_TX_NBYTES: tx_nbytes       <= pwdata[`ETH_BUF_AW:0];
            `ETH_RX_NBYTES: rx_nbytes       <= pwdata[`ETH_BUF_AW:0];
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         tx_rdy_q <= 1'b1;
         rx_rdy_q <= 1'b1;
      end else begin
         if (tx_send) begin
            tx_rdy_q <= 1'b0;
         end else if (tx_done) begin
            tx_rdy_q <= 1'b1;
         end
         if (rx_arm) begin
            rx_rdy_q <= 1'b0;
         end else if (rx_done) begin
            rx_rdy_q <= 1'b1;
         end
      end
   end

   always_comb begin
      prdata = '0;
      if (data_sel) begin
         prdata = {24'b0, rx_rdata};
      end else begin
         case (paddr)
            `ETH_STATUS:    prdata = {30'b0, rx_ready, tx_ready};
            `ETH_MAC_LO:    prdata = {8'b0, mac_addr[23:0]};
            `ETH_MAC_HI:    prdata = {8'b0, mac_addr[47:24]};
            `ETH_TX_NBYTES: prdata = 32'(tx_nbytes);
            `ETH_RX_NBYTES: prdata = 32'(rx_nbytes);
            default:        prdata = '0;
         endcase
      end
   end

endmodule

//--- eth_rx.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_rx (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 arm,
   input  eth_pkg::eth_count_t  nbytes,
   input  eth_pkg::eth_mac_t    mac_addr,
   input  logic                 rx_dv,
   input  eth_pkg::eth_nibble_t rx_data,
   output logic                 wr,
   output eth_pkg::eth_addr_t   wr_addr,
   output eth_pkg::eth_byte_t   wr_data,
   output logic                 done
);

   import eth_pkg::*;

   localparam eth_byte_t SFD = `ETH_SFD_BYTE;

   rx_state_t   state;
   eth_count_t  cnt;
   logic        phase;
   logic        prev_five;
   logic        st_ok;
   logic        bc_ok;
   eth_nibble_t low;
   eth_byte_t   rx_byte;
   eth_byte_t   mac_byte;
   logic        st_nxt;
   logic        bc_nxt;
   logic        last;

   assign rx_byte = {rx_data, low};
   assign st_nxt  = st_ok & (rx_byte == mac_byte);
   assign bc_nxt  = bc_ok & (rx_byte == 8'hFF);
   assign last    = (eth_count_t'(cnt + 1'b1) == nbytes);
   assign done    = (state == RX_DONE);

   // Station address goes out most significant byte first
   always_comb begin
      case (cnt[2:0])
         3'd0:    mac_byte = mac_addr[47:40];
         3'd1:    mac_byte = mac_addr[39:32];
         3'd2:    mac_byte = mac_addr[31:24];
         3'd3:    mac_byte = mac_addr[23:16];
         3'd4:    mac_byte = mac_addr[15:8];
         default: mac_byte = mac_addr[7:0];
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= RX_IDLE;
         cnt       <= '0;
         phase     <= 1'b0;
         prev_five <= 1'b0;
         st_ok     <= 1'b0;
         bc_ok     <= 1'b0;
         wr        <= 1'b0;
      end else begin
         wr        <= 1'b0;
         prev_five <= rx_dv && (rx_data == SFD[3:0]);
         case (state)
            RX_IDLE: begin
               if (arm) begin
                  state <= RX_HUNT;
               end
            end
            RX_HUNT: begin
               if (rx_dv && prev_five && rx_data == SFD[7:4]) begin
                  state <= RX_DEST;
                  cnt   <= '0;
                  phase <= 1'b0;
                  st_ok <= 1'b1;
                  bc_ok <= 1'b1;
               end
            end
            RX_DEST, RX_BODY: begin
               if (!rx_dv) begin
                  // Short frame, keep listening
                  state <= RX_HUNT;
               end else if (!phase) begin
                  phase <= 1'b1;
               end else begin
                  phase <= 1'b0;
                  wr    <= 1'b1;
                  cnt   <= cnt + 1'b1;
                  if (state == RX_DEST) begin
                     st_ok <= st_nxt;
                     bc_ok <= bc_nxt;
                     if (!st_nxt && !bc_nxt) begin
                        state <= RX_DROP;
                     end else if (last) begin
                        state <= RX_DONE;
                     end else if (cnt == eth_count_t'(5)) begin
                        state <= RX_BODY;
                     end
                  end else if (last) begin
                     state <= RX_DONE;
                  end
               end
            end
            RX_DONE: state <= RX_IDLE;
            RX_DROP: begin
               if (!rx_dv) begin
                  state <= RX_HUNT;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!phase) begin
         low <= rx_data;
      end else begin
         wr_addr <= cnt[`ETH_BUF_AW-1:0];
         wr_data <= rx_byte;
      end
   end

endmodule

//--- eth_top.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  logic [`ETH_APB_AW-1:0]  paddr,
   input  logic [31:0]             pwdata,
   output logic [31:0]             prdata,
   output logic                    pready,
   output logic                    pslverr,
   output logic                    tx_en,
   output eth_pkg::eth_nibble_t    tx_data,
   input  logic                    rx_dv,
   input  eth_pkg::eth_nibble_t    rx_data,
   output logic                    phy_resetn
);

   import eth_pkg::*;

   // CPU side of the buffers
   logic       tx_wr;
   eth_addr_t  tx_waddr;
   eth_byte_t  tx_wdata;
   eth_addr_t  rx_raddr;
   eth_byte_t  rx_rdata;

   // Engine side of the buffers
   eth_addr_t  tx_rd_addr;
   eth_byte_t  tx_rd_data;
   logic       rx_wr;
   eth_addr_t  rx_waddr;
   eth_byte_t  rx_wdata;

   eth_count_t tx_nbytes;
   eth_count_t rx_nbytes;
   eth_mac_t   mac_addr;
   logic       tx_send;
   logic       rx_arm;
   logic       tx_done;
   logic       rx_done;

   eth_regs u_regs (
      .clk        (clk),
      .rst        (rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .phy_resetn (phy_resetn),
      .tx_done    (tx_done),
      .rx_done    (rx_done),
      .rx_rdata   (rx_rdata),
      .tx_wr      (tx_wr),
      .tx_waddr   (tx_waddr),
      .tx_wdata   (tx_wdata),
      .rx_raddr   (rx_raddr),
      .tx_nbytes  (tx_nbytes),
      .rx_nbytes  (rx_nbytes),
      .mac_addr   (mac_addr),
      .tx_send    (tx_send),
      .rx_arm     (rx_arm)
   );

   eth_buffer #(.DEPTH_AW(`ETH_BUF_AW)) u_tx_buf (
      .clk   (clk),
      .we    (tx_wr),
      .waddr (tx_waddr),
      .raddr (tx_rd_addr),
      .wdata (tx_wdata),
      .rdata (tx_rd_data)
   );

   eth_buffer #(.DEPTH_AW(`ETH_BUF_AW)) u_rx_buf (
      .clk   (clk),
      .we    (rx_wr),
      .waddr (rx_waddr),
      .raddr (rx_raddr),
      .wdata (rx_wdata),
      .rdata (rx_rdata)
   );

   eth_tx u_tx (
      .clk     (clk),
      .rst     (rst),
      .send    (tx_send),
      .nbytes  (tx_nbytes),
      .rd_addr (tx_rd_addr),
      .rd_data (tx_rd_data),
      .tx_en   (tx_en),
      .tx_data (tx_data),
      .done    (tx_done)
   );

   eth_rx u_rx (
      .clk      (clk),
      .rst      (rst),
      .arm      (rx_arm),
      .nbytes   (rx_nbytes),
      .mac_addr (mac_addr),
      .rx_dv    (rx_dv),
      .rx_data  (rx_data),
      .wr       (rx_wr),
      .wr_addr  (rx_waddr),
      .wr_data  (rx_wdata),
      .done     (rx_done)
   );

   eth_phy_reset u_phy_rst (
      .clk        (clk),
      .rst        (rst),
      .phy_resetn (phy_resetn)
   );

endmodule

//--- eth_tx.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_tx (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 send,
   input  eth_pkg::eth_count_t  nbytes,
   output eth_pkg::eth_addr_t   rd_addr,
   input  eth_pkg::eth_byte_t   rd_data,
   output logic                 tx_en,
   output eth_pkg::eth_nibble_t tx_data,
   output logic                 done
);

   import eth_pkg::*;

   localparam eth_count_t PRE_LAST = eth_count_t'(`ETH_PREAMBLE_LEN - 1);

   tx_state_t  state;
   eth_count_t cnt;
   logic       phase;
   eth_byte_t  cur;

   assign tx_en   = (state != TX_IDLE);
   assign tx_data = tx_en ? (phase ? cur[7:4] : cur[3:0]) : '0;

   // During payload cnt already points at the next byte
   assign rd_addr = cnt[`ETH_BUF_AW-1:0];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= TX_IDLE;
         cnt   <= '0;
         phase <= 1'b0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (state == TX_IDLE) begin
            phase <= 1'b0;
            if (send) begin
               state <= TX_PREAMBLE;
               cnt   <= '0;
            end
         end else if (!phase) begin
            phase <= 1'b1;
         end else begin
            // High nibble out, move to the next byte
            phase <= 1'b0;
            case (state)
               TX_PREAMBLE: begin
                  if (cnt == PRE_LAST) begin
                     state <= TX_SFD;
                     cnt   <= '0;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
               TX_SFD: begin
                  if (nbytes == '0) begin
                     state <= TX_IDLE;
                     done  <= 1'b1;
                  end else begin
                     state <= TX_PAYLOAD;
                     cnt   <= eth_count_t'(1);
                  end
               end
               TX_PAYLOAD: begin
                  if (cnt == nbytes) begin
                     state <= TX_IDLE;
                     done  <= 1'b1;
                  end else begin
                     cnt <= cnt + 1'b1;
                  end
               end
               default: state <= TX_IDLE;
            endcase
         end
      end
   end

   // Byte on the wire
   always_ff @(posedge clk) begin
      if (state == TX_IDLE && send) begin
         cur <= `ETH_PREAMBLE_BYTE;
      end else if (phase) begin
         case (state)
            TX_PREAMBLE: begin
               if (cnt == PRE_LAST) begin
                  cur <= `ETH_SFD_BYTE;
               end
            end
            TX_SFD, TX_PAYLOAD: cur <= rd_data;
            default: ;
         endcase
      end
   end

endmodule

//--- filelist.f
+incdir+.
eth_pkg.sv
eth_buffer.sv
eth_phy_reset.sv
eth_regs.sv
eth_tx.sv
eth_rx.sv
eth_top.sv
eth_assert.sv
tb_eth.sv

//--- tb_eth.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module tb_eth;

   import eth_pkg::*;

   typedef logic [`ETH_APB_AW-1:0] apb_addr_t;

   localparam int       NUM_FRAMES = 6;
   localparam eth_mac_t STATION    = 48'h0A_1B_2C_3D_4E_5F;
   localparam eth_mac_t FOREIGN    = 48'h0A_1B_2C_3D_4E_60;
   localparam eth_mac_t OTHER      = 48'h12_34_56_78_9A_BC;
   localparam eth_mac_t BCAST      = 48'hFF_FF_FF_FF_FF_FF;

   logic        clk = 1'b0;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        tx_en;
   eth_nibble_t tx_data;
   logic        rx_dv = 1'b0;
   eth_nibble_t rx_data = '0;
   logic        phy_resetn;

   // Destination, payload length, accepted by the filter
   eth_mac_t tbl_dest [NUM_FRAMES] = '{STATION, BCAST, FOREIGN, STATION, OTHER, BCAST};
   int       tbl_len  [NUM_FRAMES] = '{8, 20, 16, 40, 10, 12};
   bit       tbl_ok   [NUM_FRAMES] = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};

   int          seed = 90;
   int          cycles = 0;
   eth_nibble_t nib_q [$];
   int          en_cycles = 0;
   int          bursts = 0;
   logic        en_prev = 1'b0;

   eth_top u_eth_top (
      .clk        (clk),
      .rst        (rst),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .tx_en      (tx_en),
      .tx_data    (tx_data),
      .rx_dv      (rx_dv),
      .rx_data    (rx_data),
      .phy_resetn (phy_resetn)
   );

   always #5 clk = ~clk;

   // MII loopback
   always @(negedge clk) begin
      rx_dv   <= tx_en;
      rx_data <= tx_data;
   end

   // Wire capture of every transmitted nibble
   always @(negedge clk) begin
      if (tx_en) begin
         nib_q.push_back(tx_data);
         en_cycles++;
         if (!en_prev) begin
            bursts++;
         end
      end
      en_prev = tx_en;
   end

   function automatic int cycle_limit();
      int sum;
      sum = 500;
      for (int i = 0; i < NUM_FRAMES; i++) begin
         sum += 2 * (8 + tbl_len[i]) + 200;
      end
      return sum;
   endfunction

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit()) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit());
         $display("TEST FAILED");
         $fatal(1, "Timeout");
      end
   end

   task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      while (!pready) begin
         @(posedge clk);
      end
      check_word({31'b0, pslverr}, 32'h0, "pslverr on write");
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output logic [31:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      while (!pready) begin
         @(posedge clk);
      end
      data = prdata;
      check_word({31'b0, pslverr}, 32'h0, "pslverr on read");
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_status(input logic [31:0] mask);
      logic [31:0] s;
      s = '0;
      while ((s & mask) != mask) begin
         apb_read(`ETH_STATUS, s);
      end
   endtask

   task automatic check_byte(input eth_byte_t got, input eth_byte_t exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Byte mismatch");
      end
   endtask

   task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Word mismatch");
      end
   endtask

   task automatic check_mac(input eth_mac_t got, input eth_mac_t exp, input string what);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TEST FAILED");
         $fatal(1, "MAC mismatch");
      end
   endtask

   initial begin
      eth_byte_t   frame [64];
      logic [31:0] rdata;
      logic [31:0] lo;
      logic [31:0] hi;
      bit          rx_armed;
      time         t_rel;
      int          len;
      int          start_cycles;
      int          start_bursts;
      int          start_nib;
      eth_byte_t   exp_b;
      eth_byte_t   got_b;

      rst      = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      rx_armed = 1'b0;
      repeat (16) @(negedge clk);
      rst   = 1'b0;
      t_rel = $time;

      // Flags are masked while the PHY is held in reset
      apb_read(`ETH_STATUS, rdata);
      check_word(rdata, 32'h0, "STATUS with PHY in reset");
      while (!phy_resetn) begin
         @(negedge clk);
      end
      check_word(32'(($time - t_rel) / 10), 32'd64, "PHY reset length");
      apb_read(`ETH_STATUS, rdata);
      check_word(rdata, 32'h3, "STATUS after PHY reset");

      apb_read(`ETH_MAC_LO, lo);
      apb_read(`ETH_MAC_HI, hi);
      check_mac({hi[23:0], lo[23:0]}, `ETH_MAC_RESET, "reset MAC address");
      apb_write(`ETH_MAC_LO, {8'h0, STATION[23:0]});
      apb_write(`ETH_MAC_HI, {8'h0, STATION[47:24]});
      apb_read(`ETH_MAC_LO, lo);
      apb_read(`ETH_MAC_HI, hi);
      check_mac({hi[23:0], lo[23:0]}, STATION, "station MAC address");

      for (int f = 0; f < NUM_FRAMES; f++) begin
         len = tbl_len[f];
         // Destination first with the most significant byte leading
         for (int i = 0; i < len; i++) begin
            if (i < 6) begin
               frame[i] = tbl_dest[f][47 - 8 * i -: 8];
            end else begin
               frame[i] = eth_byte_t'($random(seed));
            end
            apb_write(apb_addr_t'(`ETH_DATA_BASE + i), 32'(frame[i]));
         end
         apb_write(`ETH_TX_NBYTES, 32'(len));
         apb_write(`ETH_RX_NBYTES, 32'(len));
         apb_read(`ETH_TX_NBYTES, rdata);
         check_word(rdata, 32'(len), "TX_NBYTES read-back");
         apb_read(`ETH_RX_NBYTES, rdata);
         check_word(rdata, 32'(len), "RX_NBYTES read-back");
         if (!rx_armed) begin
            apb_write(`ETH_CONTROL, 32'h2);
            rx_armed = 1'b1;
         end

         start_cycles = en_cycles;
         start_bursts = bursts;
         start_nib    = nib_q.size();
         apb_write(`ETH_CONTROL, 32'h1);
         apb_read(`ETH_STATUS, rdata);
         check_word(rdata, 32'h0, $sformatf("STATUS during send of frame %0d", f));
         // Transmitter is busy so this send is ignored
         apb_write(`ETH_CONTROL, 32'h1);
         wait_status(32'h1);

         check_word(32'(en_cycles - start_cycles), 32'(2 * (8 + len)),
                    $sformatf("tx_en cycles of frame %0d", f));
         check_word(32'(bursts - start_bursts), 32'h1,
                    $sformatf("tx_en bursts of frame %0d", f));
         for (int k = 0; k < 8 + len; k++) begin
            if (k < `ETH_PREAMBLE_LEN) begin
               exp_b = `ETH_PREAMBLE_BYTE;
            end else if (k == `ETH_PREAMBLE_LEN) begin
               exp_b = `ETH_SFD_BYTE;
            end else begin
               exp_b = frame[k - 8];
            end
            got_b = {nib_q[start_nib + 2 * k + 1], nib_q[start_nib + 2 * k]};
            check_byte(got_b, exp_b, $sformatf("frame %0d wire byte %0d", f, k));
         end

         if (tbl_ok[f]) begin
            wait_status(32'h2);
            apb_read(`ETH_STATUS, rdata);
            check_word(rdata, 32'h3, $sformatf("STATUS after frame %0d", f));
            for (int i = 0; i < len; i++) begin
               apb_read(apb_addr_t'(`ETH_DATA_BASE + i), rdata);
               check_byte(rdata[7:0], frame[i], $sformatf("frame %0d rx byte %0d", f, i));
            end
            rx_armed = 1'b0;
         end else begin
            // Receiver stays armed after a filtered frame
            apb_read(`ETH_STATUS, rdata);
            check_word(rdata, 32'h1, $sformatf("STATUS after dropped frame %0d", f));
         end
      end

      if (u_eth_top.u_eth_assert.fail_cnt == 0) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         $display("Assertion failures: %0d", u_eth_top.u_eth_assert.fail_cnt);
         $display("TEST FAILED");
         $fatal(1, "Assertions failed");
      end
   end

endmodule
